// File: Makefile
TOP = dual_issue_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f dual_issue.f --top-module $(TOP)

sim:
	verilator --binary --timing -f dual_issue.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dual_issue.f
+incdir+include
verilog/dual_issue_pkg.sv
verilog/pair_receiver.sv
verilog/hazard_detection_unit.sv
verilog/issue_sequencer.sv
verilog/group_sender.sv
verilog/dual_issue_top.sv
tests/dual_issue_tb.sv

// File: include/dual_issue_checks.svh
`ifndef dual_issue_checks_svh
`define dual_issue_checks_svh

//////////////////////////////
// compare tasks

function automatic string kind_name(input group_kind_e k);
  case (k)
    grp_whole:   return "whole";
    grp_older:   return "older";
    grp_younger: return "younger";
    default:     return "bubble";
  endcase
endfunction

// one issued group against its expected value.
task automatic check_group(input string test, input group_t exp, input group_t act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("[ERROR] %s: expected %s %h %h, actual %s %h %h", test,
             kind_name(exp.kind), exp.slot0, exp.slot1,
             kind_name(act.kind), act.slot0, act.slot1);
  end
endtask

// a single handshake wire.
task automatic check_level(input string test, input string name, input logic exp,
                           input logic act);
  checks++;
  if (act !== exp) begin
    errors++;
    $display("[ERROR] %s: %s expected %b, actual %b", test, name, exp, act);
  end
endtask

task automatic report_failure(input string what);
  errors++;
  $display("%s", what);
endtask

`endif

// File: tests/dual_issue_tb.sv
module dual_issue_tb import dual_issue_pkg::*; ();

  localparam int seed           = 24;
  localparam int n_random_pairs = 30;
  localparam int n_groups       = 11 + n_random_pairs;  // directed plus stream.
  localparam int timeout_cycles = 20 * n_groups + 200;

  logic       clk;
  logic       rst;
  logic       in_req;
  logic       in_ack;
  pair_t      in_pair;
  logic       out_req;
  logic       out_ack;
  group_t     out_group;

  int         checks;
  int         errors;
  int         cycle_count;
  logic [7:0] next_id;      // fetch tag counter.
  group_t     expected[$];  // groups still owed by the DUT.
  group_t     received[$];  // groups taken by the sink.

  `include "dual_issue_checks.svh"

  dual_issue_top uut (
    .clk       (clk),
    .rst       (rst),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .in_pair   (in_pair),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .out_group (out_group)
  );

  always #4 clk = ~clk;  // period 8.

  //////////////////////////////
  // stimulus helpers

  task automatic step();
    @(posedge clk);
    #1;  // drive and sample off the edge.
  endtask

  function automatic inst_t make_inst(input opcode_e op, input reg_idx_t rs,
                                      input reg_idx_t rt, input reg_idx_t rd);
    return {op, rs, rt, rd, 11'h000};
  endfunction

  function automatic slot_t new_slot(input inst_t inst);
    slot_t s;
    next_id = next_id + 8'd1;
    s.inst  = inst;
    s.id    = next_id;
    s.pc    = 32'h0000_1000 + {22'h0, next_id, 2'b00};  // word per tag.
    return s;
  endfunction

  function automatic pair_t make_pair(input slot_t s0, input slot_t s1, input logic first);
    pair_t p;
    p.slot0 = s0;
    p.slot1 = s1;
    p.first = first;
    return p;
  endfunction

  function automatic group_t make_group(input slot_t s0, input slot_t s1,
                                        input group_kind_e kind);
    group_t g;
    g.slot0 = s0;
    g.slot1 = s1;
    g.kind  = kind;
    return g;
  endfunction

  // registers drawn from lo..hi, no lw so no load-use.
  function automatic inst_t random_inst(input int lo, input int hi);
    opcode_e op;
    int      pick;
    pick = $urandom_range(5, 0);
    case (pick)
      0:       op = op_add;
      1:       op = op_sub;
      2:       op = op_addi;
      3:       op = op_subi;
      4:       op = op_sw;
      default: op = op_jmp;
    endcase
    return make_inst(op, reg_idx_t'($urandom_range(hi, lo)),
                     reg_idx_t'($urandom_range(hi, lo)), reg_idx_t'($urandom_range(hi, lo)));
  endfunction

  //////////////////////////////
  // source and sink

  task automatic send_pair(input pair_t p);
    in_pair = p;
    in_req  = 1'b1;
    step();
    while (!in_ack) step();  // buffer may still hold a pair.
    in_req = 1'b0;
    step();
    while (in_ack) step();
  endtask

  task automatic run_sink();
    int delay;
    forever begin
      step();
      if (out_req) begin
        delay = $urandom_range(5, 0);  // 0 to 5 cycles.
        repeat (delay) step();
        received.push_back(out_group);
        out_ack = 1'b1;
        step();
        while (out_req) step();
        out_ack = 1'b0;
      end
    end
  endtask

  task automatic check_received(input string test);
    group_t exp_g;
    group_t act_g;
    while (received.size() < expected.size()) step();
    while (expected.size() > 0) begin
      exp_g = expected.pop_front();
      act_g = received.pop_front();
      check_group(test, exp_g, act_g);
    end
  endtask

  //////////////////////////////
  // directed tests

  task automatic test_reset_levels();
    repeat (8) begin
      step();
      check_level("reset_levels", "in_ack", 1'b0, in_ack);
      check_level("reset_levels", "out_req", 1'b0, out_req);
    end
  endtask

  task automatic test_whole_pair();
    slot_t s0;
    slot_t s1;
    s0 = new_slot(make_inst(op_add, 5'd1, 5'd2, 5'd3));   // r3 = r1 + r2.
    s1 = new_slot(make_inst(op_addi, 5'd5, 5'd7, 5'd0));  // r7 = r5 + imm.
    expected.push_back(make_group(s0, s1, grp_whole));
    send_pair(make_pair(s0, s1, 1'b1));
    check_received("whole_pair");
  endtask

  task automatic test_split_pair();
    slot_t a;
    slot_t b;
    a = new_slot(make_inst(op_add, 5'd1, 5'd2, 5'd4));  // older writes r4.
    b = new_slot(make_inst(op_sub, 5'd4, 5'd3, 5'd5));  // younger reads r4.
    expected.push_back(make_group(a, '0, grp_older));
    expected.push_back(make_group('0, b, grp_younger));
    send_pair(make_pair(a, b, 1'b1));
    a = new_slot(make_inst(op_addi, 5'd1, 5'd6, 5'd0));  // older in slot1 writes r6.
    b = new_slot(make_inst(op_sw, 5'd6, 5'd2, 5'd0));    // stores through r6.
    expected.push_back(make_group('0, a, grp_older));
    expected.push_back(make_group(b, '0, grp_younger));
    send_pair(make_pair(b, a, 1'b0));
    check_received("split_pair");
  endtask

  task automatic test_load_use();
    slot_t a;
    slot_t b;
    a = new_slot(make_inst(op_lw, 5'd1, 5'd5, 5'd0));    // r5 loaded.
    b = new_slot(make_inst(op_add, 5'd2, 5'd3, 5'd10));
    expected.push_back(make_group(a, b, grp_whole));
    send_pair(make_pair(a, b, 1'b1));
    a = new_slot(make_inst(op_add, 5'd5, 5'd7, 5'd6));   // uses r5 right away.
    b = new_slot(make_inst(op_addi, 5'd11, 5'd12, 5'd0));
    expected.push_back(make_group('0, '0, grp_bubble));
    expected.push_back(make_group(a, b, grp_whole));
    send_pair(make_pair(a, b, 1'b1));
    a = new_slot(make_inst(op_lw, 5'd2, 5'd7, 5'd0));    // older lw in slot1.
    b = new_slot(make_inst(op_add, 5'd7, 5'd3, 5'd9));   // younger reads r7.
    expected.push_back(make_group('0, a, grp_older));
    expected.push_back(make_group('0, '0, grp_bubble));
    expected.push_back(make_group(b, '0, grp_younger));
    send_pair(make_pair(b, a, 1'b0));
    check_received("load_use");
  endtask

  // older uses r1..r15, younger r16..r31, so pairs stay independent.
  task automatic test_random_stream();
    slot_t older;
    slot_t younger;
    logic  first;
    repeat (n_random_pairs) begin
      first   = 1'($urandom_range(1, 0));
      older   = new_slot(random_inst(1, 15));
      younger = new_slot(random_inst(16, 31));
      if (first) begin
        expected.push_back(make_group(older, younger, grp_whole));
        send_pair(make_pair(older, younger, 1'b1));
      end else begin
        expected.push_back(make_group(younger, older, grp_whole));
        send_pair(make_pair(younger, older, 1'b0));
      end
    end
    check_received("random_stream");
  endtask

  //////////////////////////////
  // run control

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(seed));
    clk     = 1'b0;
    rst     = 1'b1;
    in_req  = 1'b0;
    in_pair = '0;
    out_ack = 1'b0;
    checks  = 0;
    errors  = 0;
    next_id = 8'd0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      run_sink();
    join_none
    test_reset_levels();
    test_whole_pair();
    test_split_pair();
    test_load_use();
    test_random_stream();
    repeat (20) step();  // let any stray group show up.
    if (received.size() != 0) begin
      report_failure($sformatf("%0d groups arrived beyond the expected ones",
                               received.size()));
    end
    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog/dual_issue_pkg.sv
package dual_issue_pkg;

  //////////////////////////////
  // instruction format

  localparam int opcode_msb = 31;  // 6-bit opcode.
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;  // first source.
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;  // second source or immediate dest.
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;  // register-register dest.
  localparam int rd_lsb     = 11;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // top two opcode bits give the class.
  typedef enum logic [5:0] {
    op_nop  = 6'b000000,  // all-zero word.
    op_jr   = 6'b000001,  // sits in class 00 but decodes on its own.
    op_add  = 6'b000010,  // class 00 register ops.
    op_sub  = 6'b000011,
    op_addi = 6'b010000,  // class 01 immediate ops.
    op_subi = 6'b010001,
    op_lw   = 6'b100000,  // class 10 memory ops.
    op_sw   = 6'b100001,
    op_la   = 6'b100010,
    op_sa   = 6'b100011,
    op_jmp  = 6'b110000,  // class 11 jumps.
    op_je   = 6'b110001
  } opcode_e;

  function automatic opcode_e inst_opcode(input inst_t inst);
    return opcode_e'(inst[opcode_msb:opcode_lsb]);
  endfunction

  function automatic reg_idx_t inst_rs(input inst_t inst);
    return inst[rs_msb:rs_lsb];
  endfunction

  function automatic reg_idx_t inst_rt(input inst_t inst);
    return inst[rt_msb:rt_lsb];
  endfunction

  function automatic reg_idx_t inst_rd(input inst_t inst);
    return inst[rd_msb:rd_lsb];
  endfunction

  //////////////////////////////
  // slots, pairs and groups

  typedef struct packed {
    inst_t       inst;  // raw instruction word.
    logic [31:0] pc;
    logic [7:0]  id;    // fetch tag.
  } slot_t;              // all zero reads as a nop.

  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
    logic  first;  // slot0 is the older one.
  } pair_t;

  typedef enum logic [1:0] {
    grp_whole,    // both slots together.
    grp_older,    // older half of a split pair.
    grp_younger,  // what is left after a split.
    grp_bubble    // all-nop group for a load-use stall.
  } group_kind_e;

  typedef struct packed {
    slot_t       slot0;
    slot_t       slot1;
    group_kind_e kind;
  } group_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t idx;  // rt of an issued lw.
  } watch_entry_t;

  typedef struct packed {
    watch_entry_t [1:0] entry;  // one per slot.
  } load_watch_t;

endpackage

// File: verilog/dual_issue_top.sv
module dual_issue_top import dual_issue_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   in_req,     // pair handshake from fetch.
  output logic   in_ack,
  input  pair_t  in_pair,
  output logic   out_req,    // group handshake to execute.
  input  logic   out_ack,
  output group_t out_group
);

  //////////////////////////////
  // internal links

  pair_t       pair;
  logic        pair_valid;
  logic        pair_done;
  logic        load_stall;
  logic        split_stall;
  logic        split_phase;
  load_watch_t load_watch;
  group_t      group;
  logic        group_valid;
  logic        group_ready;

  pair_receiver u_rx (
    .clk        (clk),
    .rst        (rst),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .in_pair    (in_pair),
    .pair       (pair),
    .pair_valid (pair_valid),
    .pair_done  (pair_done)
  );

  hazard_detection_unit u_hdu (
    .pair        (pair),
    .load_watch  (load_watch),
    .split_phase (split_phase),
    .load_stall  (load_stall),
    .split_stall (split_stall)
  );

  issue_sequencer u_seq (
    .clk         (clk),
    .rst         (rst),
    .pair        (pair),
    .pair_valid  (pair_valid),
    .pair_done   (pair_done),
    .load_stall  (load_stall),
    .split_stall (split_stall),
    .split_phase (split_phase),
    .load_watch  (load_watch),
    .group       (group),
    .group_valid (group_valid),
    .group_ready (group_ready)
  );

  group_sender u_tx (
    .clk         (clk),
    .rst         (rst),
    .group       (group),
    .group_valid (group_valid),
    .group_ready (group_ready),
    .out_req     (out_req),
    .out_ack     (out_ack),
    .out_group   (out_group)
  );

endmodule

// File: verilog/group_sender.sv
module group_sender import dual_issue_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  group_t group,
  input  logic   group_valid,
  output logic   group_ready,  // idle and free for a group.
  output logic   out_req,      // four-phase request to the sink.
  input  logic   out_ack,
  output group_t out_group     // stable while out_req is high.
);

  typedef enum logic [1:0] {
    st_idle,      // no group held.
    st_req,       // raise req and wait for ack.
    st_wait_low   // wait for ack to drop.
  } state_e;

  state_e state;
  logic   take;

  assign group_ready = state == st_idle;
  assign take        = group_valid && group_ready;

  //////////////////////////////
  // request state

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      out_req <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (!out_req) begin
            out_req <= 1'b1;  // data settled one cycle ahead.
          end else if (out_ack) begin
            out_req <= 1'b0;
            state   <= st_wait_low;
          end
        end
        st_wait_low: begin
          if (!out_ack) begin
            state <= st_idle;  // ready again next cycle.
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_group <= group;
    end
  end

endmodule

// File: verilog/hazard_detection_unit.sv
module hazard_detection_unit import dual_issue_pkg::*; (
  input  pair_t       pair,         // buffered pair under issue.
  input  load_watch_t load_watch,   // loads of the last group.
  input  logic        split_phase,  // only the younger slot is left.
  output logic        load_stall,
  output logic        split_stall
);

  //////////////////////////////
  // register use masks

  localparam logic [2:0] mask_rs = 3'b001;
  localparam logic [2:0] mask_rt = 3'b010;
  localparam logic [2:0] mask_rd = 3'b100;

  typedef struct packed {
    logic [2:0] src;  // fields read.
    logic [2:0] dst;  // fields written.
  } reg_mask_t;

  slot_t     older;
  slot_t     younger;
  reg_mask_t older_mask;
  reg_mask_t younger_mask;
  reg_idx_t  older_dst;         // rt or rd of the older slot.
  logic      older_writes;
  logic      older_load_hit;
  logic      younger_load_hit;
  logic      pair_dep;          // younger reads older's dest.

  // opcode to source and dest fields.
  function automatic reg_mask_t decode(input inst_t inst);
    reg_mask_t m;
    opcode_e   opc;
    m   = '0;
    opc = inst_opcode(inst);
    if (opc == op_jr) begin
      m.src = mask_rs;  // jump target only.
    end else if (opc != op_nop) begin
      case (opc[5:4])
        2'b00: begin  // add, sub.
          m.src = mask_rs | mask_rt;
          m.dst = mask_rd;
        end
        2'b01: begin  // addi, subi.
          m.src = mask_rs;
          m.dst = mask_rt;
        end
        2'b10: begin  // memory ops differ one by one.
          case (opc)
            op_lw: begin
              m.src = mask_rs;
              m.dst = mask_rt;
            end
            op_sw:   m.src = mask_rs | mask_rt;
            op_la:   m.dst = mask_rt;
            op_sa:   m.src = mask_rt;
            default: m = '0;
          endcase
        end
        default: m = '0;  // jmp, je touch no registers.
      endcase
    end
    return m;
  endfunction

  // does the slot read register r.
  function automatic logic reads(input inst_t inst, input reg_mask_t m, input reg_idx_t r);
    return (|(m.src & mask_rs) && inst_rs(inst) == r) ||
           (|(m.src & mask_rt) && inst_rt(inst) == r);
  endfunction

  function automatic logic load_hit(input inst_t inst, input reg_mask_t m,
                                    input load_watch_t w);
    return (w.entry[0].valid && reads(inst, m, w.entry[0].idx)) ||
           (w.entry[1].valid && reads(inst, m, w.entry[1].idx));
  endfunction

  //////////////////////////////
  // age order

  always_comb begin
    if (pair.first) begin
      older   = pair.slot0;
      younger = pair.slot1;
    end else begin
      older   = pair.slot1;  // slot1 came first.
      younger = pair.slot0;
    end
  end

  assign older_mask   = decode(older.inst);
  assign younger_mask = decode(younger.inst);

  assign older_writes = |older_mask.dst;
  assign older_dst    = |(older_mask.dst & mask_rd) ? inst_rd(older.inst)
                                                    : inst_rt(older.inst);

  //////////////////////////////
  // hazard flags

  assign older_load_hit   = load_hit(older.inst, older_mask, load_watch);
  assign younger_load_hit = load_hit(younger.inst, younger_mask, load_watch);
  assign pair_dep         = older_writes && reads(younger.inst, younger_mask, older_dst);

  // older slot already gone in split phase.
  assign load_stall  = younger_load_hit || (!split_phase && older_load_hit);
  assign split_stall = !split_phase && pair_dep;

endmodule

// File: verilog/issue_sequencer.sv
module issue_sequencer import dual_issue_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  pair_t       pair,
  input  logic        pair_valid,
  output logic        pair_done,    // last group of the pair taken.
  input  logic        load_stall,
  input  logic        split_stall,
  output logic        split_phase,  // older slot already issued.
  output load_watch_t load_watch,
  output group_t      group,
  output logic        group_valid,
  input  logic        group_ready
);

  typedef enum logic [1:0] {
    st_idle,     // build from a fresh pair.
    st_issue,    // group waiting for the sender.
    st_younger   // build the younger half.
  } state_e;

  state_e      state;
  logic        split_q;     // set between older and younger groups.
  logic        build;       // load a new group this edge.
  logic        handoff;
  logic        last;        // group finishes its pair.
  group_t      next_group;
  load_watch_t next_watch;

  assign split_phase = split_q;
  assign build       = pair_valid && (state == st_idle || state == st_younger);
  assign handoff     = group_valid && group_ready;
  assign last        = group.kind == grp_whole || group.kind == grp_younger;
  assign pair_done   = handoff && last;

  //////////////////////////////
  // group selection

  always_comb begin
    next_group = '0;  // unused slots go out as nops.
    if (load_stall) begin
      next_group.kind = grp_bubble;
    end else if (state == st_younger) begin
      next_group.kind = grp_younger;  // younger keeps its position.
      if (pair.first) begin
        next_group.slot1 = pair.slot1;
      end else begin
        next_group.slot0 = pair.slot0;
      end
    end else if (split_stall) begin
      next_group.kind = grp_older;
      if (pair.first) begin
        next_group.slot0 = pair.slot0;
      end else begin
        next_group.slot1 = pair.slot1;
      end
    end else begin
      next_group.kind  = grp_whole;
      next_group.slot0 = pair.slot0;
      next_group.slot1 = pair.slot1;
    end
  end

  // loads in the outgoing group, a bubble clears it.
  always_comb begin
    next_watch.entry[0].valid = inst_opcode(group.slot0.inst) == op_lw;
    next_watch.entry[0].idx   = inst_rt(group.slot0.inst);
    next_watch.entry[1].valid = inst_opcode(group.slot1.inst) == op_lw;
    next_watch.entry[1].idx   = inst_rt(group.slot1.inst);
  end

  //////////////////////////////
  // state machine

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      split_q     <= 1'b0;
      group_valid <= 1'b0;
      load_watch  <= '0;
    end else begin
      case (state)
        st_idle, st_younger: begin
          if (build) begin
            group_valid <= 1'b1;
            state       <= st_issue;
          end
        end
        st_issue: begin
          if (handoff) begin
            group_valid <= 1'b0;
            load_watch  <= next_watch;  // hazards of the next group see this.
            if (last) begin
              split_q <= 1'b0;
              state   <= st_idle;
            end else if (group.kind == grp_older || split_q) begin
              split_q <= 1'b1;  // younger half still pending.
              state   <= st_younger;
            end else begin
              state <= st_idle;  // bubble before a fresh pair.
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (build) begin
      group <= next_group;
    end
  end

endmodule

// File: verilog/pair_receiver.sv
module pair_receiver import dual_issue_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_req,      // four-phase request from fetch.
  output logic  in_ack,
  input  pair_t in_pair,     // stable while in_req is high.
  output pair_t pair,        // buffered pair.
  output logic  pair_valid,
  input  logic  pair_done    // last group of the pair handed over.
);

  //////////////////////////////
  // handshake control

  logic capture;  // take the pair at this edge.
  logic release_ack;

  // ack low means the last handshake is finished.
  assign capture     = in_req && !in_ack && !pair_valid;
  assign release_ack = in_ack && !in_req;  // source has seen ack.

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ack     <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      if (capture) begin
        in_ack     <= 1'b1;  // ack one cycle after capture edge.
        pair_valid <= 1'b1;
      end else if (pair_done) begin
        pair_valid <= 1'b0;  // empties with the last handoff.
      end

      if (release_ack) begin
        in_ack <= 1'b0;  // return to zero.
      end
    end
  end

  //////////////////////////////
  // pair buffer

  always_ff @(posedge clk) begin
    if (capture) begin
      pair <= in_pair;
    end
  end

endmodule
